/* dv/tb_iq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 256-word program memory, wraps on pc[9:2]; bht answer is a fixed random table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "iq_cfg.svh"

module tb_iq;

	logic                       clk;
	logic                       rst;
	logic                       flush;
	logic [`XLEN-1:0]           flush_pc;
	logic [`XLEN-1:0]           icache_addr;
	logic                       icache_hit;
	logic [`XLEN-1:0]           icache_data;
	logic                       icache_fill;
	logic [`XLEN-1:0]           icache_fill_addr;
	logic [`XLEN-1:0]           icache_fill_data;
	logic                       mem_req;
	logic [`XLEN-1:0]           mem_addr;
	logic                       mem_ok;
	logic [`XLEN-1:0]           mem_data;
	logic [`BHT_INDEX_BITS-1:0] bht_index;
	logic                       bht_taken;
	logic                       rob_full;
	iq_pkg::rob_tag_t           rob_tail_tag;
	logic                       rob_alloc;
	logic [`XLEN-1:0]           rob_pc;
	logic [`XLEN-1:0]           rob_inst;
	iq_pkg::inst_class_e        rob_class;
	logic [4:0]                 rob_dest;
	logic [`XLEN-1:0]           rob_target;
	logic                       rob_pred_taken;
	logic                       rs_free;
	iq_pkg::rs_idx_t            rs_free_idx;
	logic                       rs_alloc;
	iq_pkg::rs_idx_t            rs_idx;
	logic [`XLEN-1:0]           rs_inst;
	logic [`XLEN-1:0]           rs_pc;
	logic [`XLEN-1:0]           rs_imm;
	logic [`XLEN-1:0]           rs_target;
	iq_pkg::rob_tag_t           rs_tag;
	logic                       slb_full;
	logic                       slb_alloc;
	logic [`XLEN-1:0]           slb_inst;
	logic [`XLEN-1:0]           slb_pc;
	logic [`XLEN-1:0]           slb_imm;
	iq_pkg::rob_tag_t           slb_tag;
	logic                       rename_we;
	logic [4:0]                 rename_rd;
	iq_pkg::rob_tag_t           rename_tag;

	iq_top i_iq_top (.*);

	// external models
	logic [31:0] imem [256];
	logic        bht_tab [4096]; // fixed random prediction per index
	logic        cache_valid [256];
	logic [31:0] cache_tag [256];
	logic [31:0] cache_data [256];
	logic        mem_busy; // one request in flight
	int          mem_cnt;
	logic [31:0] mem_addr_q;

	// reference model state
	logic [31:0] exp_pc; // pc of the next instruction expected at dispatch
	logic [31:0] flush_pc_q;
	logic        addr_pending;
	logic [31:0] lcg_state;
	int          hit_pct;
	logic        bp_on;
	logic        flush_on;
	logic        aborted; // a test ran out of cycles
	int          n_disp;
	int          n_req;
	int          n_flush;
	int          n_tests;
	int          checks;
	int          errors;
	int          req0;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {16'd0, lcg_state[31:16]}; // upper half, better spread
	endfunction

	function automatic int rand_below(input int n);
		return int'(rand_next() % 32'(n));
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// random word for address i; targets land in words 64..255
	function automatic logic [31:0] gen_word(input int i, input logic ctrl);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] i12;
		logic [31:0] off;
		int          kind;
		int          t;
		rd   = 5'(rand_next());
		rs1  = 5'(rand_next());
		rs2  = 5'(rand_next());
		i12  = 12'(rand_next());
		kind = ctrl ? rand_below(10) : rand_below(6);
		t    = 64 + rand_below(192);
		off  = 32'((t - i) * 4);
		case (kind)
			0: return {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
			1, 5: return {i12, rs1, 3'b000, rd, 7'b0010011};
			2: return {20'(rand_next()), rd, rand_below(2) == 0 ? 7'b0110111 : 7'b0010111};
			3: return {i12, rs1, 3'b010, rd, 7'b0000011};
			4: return {i12[11:5], rs2, rs1, 3'b010, i12[4:0], 7'b0100011};
			6, 7: return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
			8: return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
			default: return {i12, rs1, 3'b000, rd, 7'b1100111}; // jalr
		endcase
	endfunction

	// classification straight from the opcode table
	function automatic iq_pkg::inst_class_e model_class(input logic [31:0] w);
		case (w[6:0])
			7'b0110011, 7'b0010011: return iq_pkg::class_alu;
			7'b0110111, 7'b0010111: return iq_pkg::class_lui_auipc;
			7'b1100011: return iq_pkg::class_branch;
			7'b1101111: return iq_pkg::class_jal;
			7'b1100111: return iq_pkg::class_jalr;
			7'b0000011: return iq_pkg::class_load;
			7'b0100011: return iq_pkg::class_store;
			default: return iq_pkg::class_illegal;
		endcase
	endfunction

	function automatic logic [31:0] model_imm(input logic [31:0] w);
		case (w[6:0])
			7'b0010011, 7'b1100111, 7'b0000011: return {{20{w[31]}}, w[31:20]};
			7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
			7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
			7'b1100011: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			7'b1101111: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: return 32'd0; // reg-reg ops carry none
		endcase
	endfunction

	task automatic observe();
		logic [31:0]         inst;
		logic [31:0]         imm;
		iq_pkg::inst_class_e cls;
		logic                is_mem;
		logic                is_br;
		logic                taken;
		logic                stall;
		if (addr_pending) begin
			check("fetch address after flush", icache_addr, flush_pc_q);
			addr_pending = 1'b0;
		end
		if (!mem_ok)
			check("bht_index", 32'(bht_index), 32'(icache_data[11:0])); // cache word is fetched
		check("icache_fill without mem_ok", 32'(icache_fill), 32'(mem_ok));
		if (mem_ok) begin
			check("fill address", icache_fill_addr, mem_addr_q);
			check("fill data", icache_fill_data, imem[mem_addr_q[9:2]]);
			cache_valid[mem_addr_q[9:2]] = 1'b1;
			cache_tag[mem_addr_q[9:2]]   = mem_addr_q;
			cache_data[mem_addr_q[9:2]]  = mem_data;
			mem_busy = 1'b0;
		end
		if (mem_req) begin
			check("request while one outstanding", 32'(mem_busy), 32'd0);
			check("mem_addr vs fetch pc", mem_addr, icache_addr);
			mem_busy   = 1'b1;
			mem_cnt    = 1 + rand_below(6); // latency 1..6
			mem_addr_q = mem_addr;
			n_req++;
		end
		inst   = imem[exp_pc[9:2]];
		cls    = model_class(inst);
		imm    = model_imm(inst);
		is_mem = (cls == iq_pkg::class_load) || (cls == iq_pkg::class_store);
		is_br  = (cls == iq_pkg::class_branch);
		taken  = bht_tab[inst[11:0]];
		stall  = rob_full || (is_mem ? slb_full : !rs_free) || flush;
		if (rob_alloc) begin
			check("strobe while stalled", 32'(stall), 32'd0);
			check("rob_pc", rob_pc, exp_pc);
			check("rob_inst", rob_inst, inst);
			check("rob_class", 32'(rob_class), 32'(cls));
			check("rob_dest", 32'(rob_dest),
				(is_br || cls == iq_pkg::class_store) ? 32'd0 : 32'(inst[11:7]));
			check("rob_target", rob_target, is_br ? exp_pc + imm : 32'd0);
			check("rob_pred_taken", 32'(rob_pred_taken), is_br ? 32'(taken) : 32'd0);
			check("rs_alloc", 32'(rs_alloc), 32'(!is_mem));
			check("slb_alloc", 32'(slb_alloc), 32'(is_mem));
			if (is_mem) begin
				check("slb_tag", 32'(slb_tag), 32'(rob_tail_tag));
				check("slb_inst", slb_inst, inst);
				check("slb_imm", slb_imm, imm);
				check("slb_pc", slb_pc, exp_pc);
			end else begin
				check("rs_tag", 32'(rs_tag), 32'(rob_tail_tag));
				check("rs_idx", 32'(rs_idx), 32'(rs_free_idx));
				check("rs_inst", rs_inst, inst);
				check("rs_imm", rs_imm, imm);
				check("rs_pc", rs_pc, exp_pc);
				check("rs_target", rs_target, is_br ? exp_pc + imm : 32'd0);
			end
			check("rename_we", 32'(rename_we), 32'(!(is_br || cls == iq_pkg::class_store)));
			if (rename_we) begin
				check("rename_rd", 32'(rename_rd), 32'(inst[11:7]));
				check("rename_tag", 32'(rename_tag), 32'(rob_tail_tag));
			end
			// follow the prediction rules
			if (cls == iq_pkg::class_jal || (is_br && taken))
				exp_pc = exp_pc + imm;
			else
				exp_pc = exp_pc + 32'd4;
			n_disp++;
		end else begin
			check("strobes without rob_alloc", {29'd0, rs_alloc, slb_alloc, rename_we}, 32'd0);
		end
		if (flush) begin
			exp_pc       = flush_pc; // older path must never show up
			flush_pc_q   = flush_pc;
			addr_pending = 1'b1;
			n_flush++;
		end
	endtask

	// one clock: drive after the edge, look at the falling edge
	task automatic step();
		logic [7:0] idx;
		@(posedge clk);
		#2;
		rst   = 1'b0;
		flush = 1'b0;
		if (flush_on && rand_below(40) == 0) begin
			flush    = 1'b1;
			flush_pc = {22'd0, 8'(64 + rand_below(192)), 2'b00};
		end
		mem_ok = 1'b0;
		if (mem_busy) begin
			mem_cnt--;
			if (mem_cnt == 0) begin
				mem_ok   = 1'b1;
				mem_data = imem[mem_addr_q[9:2]];
			end
		end
		idx         = icache_addr[9:2];
		icache_data = cache_data[idx];
		icache_hit  = cache_valid[idx] && (cache_tag[idx] == icache_addr) &&
			(rand_below(100) < hit_pct);
		if (bp_on) begin
			rob_full = (rand_below(4) == 0);
			rs_free  = (rand_below(3) != 0);
			slb_full = (rand_below(3) == 0);
		end else begin
			rob_full = 1'b0;
			rs_free  = 1'b1;
			slb_full = 1'b0;
		end
		rob_tail_tag = 4'(rand_next());
		rs_free_idx  = 3'(rand_next());
		#1;
		bht_taken = bht_tab[bht_index]; // table answers the index fetch drives
		@(negedge clk);
		observe();
	endtask

	task automatic run_test(input string name, input int count, input int limit);
		int cyc;
		int start_disp;
		int start_err;
		cyc        = 0;
		start_disp = n_disp;
		start_err  = errors;
		if (aborted)
			return; // an earlier test already ran out of cycles
		while ((n_disp - start_disp) < count && cyc < limit) begin
			step();
			cyc++;
		end
		if ((n_disp - start_disp) < count) begin
			$display("timeout: test %s dispatched only %0d of %0d within %0d cycles",
				name, n_disp - start_disp, count, limit);
			errors++;
			aborted = 1'b1;
		end else begin
			n_tests++;
			$display("test %s: %0d dispatched in %0d cycles, %0d errors",
				name, count, cyc, errors - start_err);
		end
	endtask

	initial begin
		lcg_state    = 32'd54391;
		rst          = 1'b1;
		flush        = 1'b0;
		flush_pc     = 32'd0;
		icache_hit   = 1'b0;
		icache_data  = 32'd0;
		mem_ok       = 1'b0;
		mem_data     = 32'd0;
		bht_taken    = 1'b0;
		rob_full     = 1'b0;
		rob_tail_tag = '0;
		rs_free      = 1'b1;
		rs_free_idx  = '0;
		slb_full     = 1'b0;
		mem_busy     = 1'b0;
		mem_cnt      = 0;
		mem_addr_q   = 32'd0;
		exp_pc       = `RESET_PC;
		flush_pc_q   = 32'd0;
		addr_pending = 1'b0;
		hit_pct      = 70;
		bp_on        = 1'b0;
		flush_on     = 1'b0;
		aborted      = 1'b0;
		n_disp       = 0;
		n_req        = 0;
		n_flush      = 0;
		n_tests      = 0;
		checks       = 0;
		errors       = 0;
		// words 0..63 straight-line, the rest mixed control flow
		for (int i = 0; i < 256; i++) begin
			imem[i]        = gen_word(i, i >= 64);
			cache_valid[i] = 1'b0;
			cache_tag[i]   = 32'd0;
			cache_data[i]  = 32'd0;
		end
		for (int i = 0; i < 4096; i++)
			bht_tab[i] = rand_next() & 32'd1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check("reset pc", icache_addr, `RESET_PC);
		check("reset strobes",
			{26'd0, mem_req, icache_fill, rob_alloc, rs_alloc, slb_alloc, rename_we}, 32'd0);
		run_test("straight_line", 40, 2000);
		hit_pct = 0; // every lookup misses
		req0    = n_req;
		run_test("miss_and_fill", 40, 3000);
		check("memory requests issued", 32'(n_req > req0), 32'd1);
		hit_pct = 70;
		run_test("control_flow", 150, 4000);
		run_test("routing_and_tags", 100, 3000);
		bp_on = 1'b1;
		run_test("back_pressure", 200, 6000);
		flush_on = 1'b1;
		run_test("flush", 100, 6000);
		check("flushes applied", 32'(n_flush > 0), 32'd1);
		$display("%0d tests, %0d dispatched, %0d requests, %0d flushes, %0d checks, %0d errors",
			n_tests, n_disp, n_req, n_flush, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* hw/dispatch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// purely combinational; strobes are valid for one cycle with the pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "iq_cfg.svh"

module dispatch_unit (
	input  iq_pkg::iq_entry_t   head,
	input  logic                not_empty,
	output logic                pop,
	// rob
	input  logic                rob_full,
	input  iq_pkg::rob_tag_t    rob_tail_tag,
	output logic                rob_alloc,
	output logic [`XLEN-1:0]    rob_pc,
	output logic [`XLEN-1:0]    rob_inst,
	output iq_pkg::inst_class_e rob_class,
	output logic [4:0]          rob_dest,
	output logic [`XLEN-1:0]    rob_target,
	output logic                rob_pred_taken,
	// reservation station
	input  logic                rs_free,
	input  iq_pkg::rs_idx_t     rs_free_idx,
	output logic                rs_alloc,
	output iq_pkg::rs_idx_t     rs_idx,
	output logic [`XLEN-1:0]    rs_inst,
	output logic [`XLEN-1:0]    rs_pc,
	output logic [`XLEN-1:0]    rs_imm,
	output logic [`XLEN-1:0]    rs_target,
	output iq_pkg::rob_tag_t    rs_tag,
	// store/load buffer
	input  logic                slb_full,
	output logic                slb_alloc,
	output logic [`XLEN-1:0]    slb_inst,
	output logic [`XLEN-1:0]    slb_pc,
	output logic [`XLEN-1:0]    slb_imm,
	output iq_pkg::rob_tag_t    slb_tag,
	// rename table
	output logic                rename_we,
	output logic [4:0]          rename_rd,
	output iq_pkg::rob_tag_t    rename_tag
);

	logic is_mem;   // load or store, needs an slb entry
	logic no_rd;    // branch or store
	logic slot_ok;  // the target unit has room
	logic issue;

	assign is_mem = (head.cls == iq_pkg::class_load) || (head.cls == iq_pkg::class_store);
	assign no_rd  = (head.cls == iq_pkg::class_branch) || (head.cls == iq_pkg::class_store);

	assign slot_ok = is_mem ? !slb_full : rs_free;
	assign issue   = not_empty && !rob_full && slot_ok;

	assign pop       = issue; // head leaves with the strobes
	assign rob_alloc = issue;
	assign rs_alloc  = issue && !is_mem;
	assign slb_alloc = issue && is_mem;
	assign rename_we = issue && !no_rd;

	// payload straight from the head, qualified by the strobes
	assign rob_pc         = head.pc;
	assign rob_inst       = head.inst;
	assign rob_class      = head.cls;
	assign rob_dest       = head.rd;
	assign rob_target     = head.target;
	assign rob_pred_taken = head.pred_taken;

	assign rs_idx    = rs_free_idx;
	assign rs_inst   = head.inst;
	assign rs_pc     = head.pc;
	assign rs_imm    = head.imm;
	assign rs_target = head.target;
	assign rs_tag    = rob_tail_tag;

	assign slb_inst = head.inst;
	assign slb_pc   = head.pc;
	assign slb_imm  = head.imm;
	assign slb_tag  = rob_tail_tag;

	// new producer of rd is the rob slot just taken
	assign rename_rd  = head.rd;
	assign rename_tag = rob_tail_tag;

endmodule

/* hw/fetch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one miss outstanding; jalr is always predicted to fall through
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "iq_cfg.svh"

module fetch_unit (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        flush,
	input  logic [`XLEN-1:0]            flush_pc,
	output logic [`XLEN-1:0]            icache_addr,
	input  logic                        icache_hit,
	input  logic [`XLEN-1:0]            icache_data,
	output logic                        icache_fill,
	output logic [`XLEN-1:0]            icache_fill_addr,
	output logic [`XLEN-1:0]            icache_fill_data,
	output logic                        mem_req,
	output logic [`XLEN-1:0]            mem_addr,
	input  logic                        mem_ok,
	input  logic [`XLEN-1:0]            mem_data,
	output logic [`BHT_INDEX_BITS-1:0]  bht_index,
	input  logic                        bht_taken,
	input  logic                        iq_full,
	output logic                        push,
	output iq_pkg::iq_entry_t           push_entry
);

	logic [`XLEN-1:0]    pc;
	logic [`XLEN-1:0]    req_addr;   // address of the miss in flight
	logic                waiting;    // request out, answer not yet back
	logic                discard;    // answer in flight belongs to a flushed path
	logic                can_fetch;
	logic                take_hit;
	logic                take_mem;
	logic [`XLEN-1:0]    fetch_inst;
	logic [`XLEN-1:0]    pc_plus4;
	logic [`XLEN-1:0]    pc_plus_imm;
	logic [`XLEN-1:0]    next_pc;
	iq_pkg::inst_class_e dec_class;
	logic [4:0]          dec_rd;
	logic [`XLEN-1:0]    dec_imm;
	logic                dec_rs1;
	logic                dec_rs2;

	// lookup only when idle with room in the queue
	assign can_fetch = !rst && !waiting && !iq_full && !flush;
	assign take_hit  = can_fetch && icache_hit;
	assign take_mem  = mem_ok && waiting && !discard && !flush;
	assign push      = take_hit || take_mem;

	assign icache_addr = pc;
	assign mem_req     = can_fetch && !icache_hit; // single-cycle pulse, waiting rises next
	assign mem_addr    = pc;

	// write every answer back, stale or not, the data is right for its address
	assign icache_fill      = mem_ok && waiting;
	assign icache_fill_addr = req_addr;
	assign icache_fill_data = mem_data;

	assign fetch_inst = take_mem ? mem_data : icache_data;
	assign bht_index  = fetch_inst[`BHT_INDEX_BITS-1:0];

	inst_decode i_inst_decode (
		.inst       (fetch_inst),
		.inst_class (dec_class),
		.rd         (dec_rd),
		.imm        (dec_imm),
		.needs_rs1  (dec_rs1),
		.needs_rs2  (dec_rs2)
	);

	assign pc_plus4    = pc + `XLEN'(4);
	assign pc_plus_imm = pc + dec_imm;

	// static jal, bht for branches, jalr falls through
	always_comb begin
		case (dec_class)
			iq_pkg::class_jal:    next_pc = pc_plus_imm;
			iq_pkg::class_branch: next_pc = bht_taken ? pc_plus_imm : pc_plus4;
			default:              next_pc = pc_plus4;
		endcase
	end

	always_comb begin
		push_entry            = '0;
		push_entry.inst       = fetch_inst;
		push_entry.pc         = pc;
		push_entry.cls        = dec_class;
		push_entry.rd         = dec_rd;
		push_entry.imm        = dec_imm;
		push_entry.needs_rs1  = dec_rs1;
		push_entry.needs_rs2  = dec_rs2;
		if (dec_class == iq_pkg::class_branch) begin
			push_entry.target     = pc_plus_imm;
			push_entry.pred_taken = bht_taken;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= `RESET_PC;
			waiting <= 1'b0;
			discard <= 1'b0;
		end else if (flush) begin
			pc      <= flush_pc;
			waiting <= waiting && !mem_ok; // controller still owes us an answer
			discard <= waiting && !mem_ok;
		end else begin
			if (mem_req)
				waiting <= 1'b1;
			if (mem_ok) begin
				waiting <= 1'b0;
				discard <= 1'b0;
			end
			if (push)
				pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req)
			req_addr <= pc;
	end

	// the controller only answers a request in flight
	assert property (@(posedge clk) disable iff (rst) mem_ok |-> waiting)
		else $error("mem_ok with no request outstanding");

endmodule

/* hw/inst_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i opcode classes only; funct fields are not checked
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "iq_cfg.svh"

module inst_decode (
	input  logic [`XLEN-1:0]   inst,
	output iq_pkg::inst_class_e inst_class,
	output logic [4:0]         rd,
	output logic [`XLEN-1:0]   imm,
	output logic               needs_rs1,
	output logic               needs_rs2
);

	logic [6:0]       opcode;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic             has_rd;

	assign opcode = inst[6:0];

	// sign-extended immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'h000};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		inst_class = iq_pkg::class_illegal;
		imm        = '0;
		case (opcode)
			7'b0110011: inst_class = iq_pkg::class_alu; // reg-reg, no imm
			7'b0010011: begin
				inst_class = iq_pkg::class_alu;
				imm        = imm_i;
			end
			7'b0110111, 7'b0010111: begin // lui, auipc
				inst_class = iq_pkg::class_lui_auipc;
				imm        = imm_u;
			end
			7'b1100011: begin
				inst_class = iq_pkg::class_branch;
				imm        = imm_b;
			end
			7'b1101111: begin
				inst_class = iq_pkg::class_jal;
				imm        = imm_j;
			end
			7'b1100111: begin
				inst_class = iq_pkg::class_jalr;
				imm        = imm_i;
			end
			7'b0000011: begin
				inst_class = iq_pkg::class_load;
				imm        = imm_i;
			end
			7'b0100011: begin
				inst_class = iq_pkg::class_store;
				imm        = imm_s;
			end
			default: ; // stays illegal, imm zero
		endcase
	end

	// branch, store and illegal write no register
	assign has_rd = (inst_class != iq_pkg::class_branch) &&
		(inst_class != iq_pkg::class_store) && (inst_class != iq_pkg::class_illegal);
	assign rd = has_rd ? inst[11:7] : 5'd0;

	// only lui, auipc and jal skip rs1
	assign needs_rs1 = (inst_class != iq_pkg::class_lui_auipc) &&
		(inst_class != iq_pkg::class_jal);
	assign needs_rs2 = (opcode == 7'b0110011) || (inst_class == iq_pkg::class_branch) ||
		(inst_class == iq_pkg::class_store);

endmodule

/* hw/inst_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular queue; writer must respect full, reader must respect not_empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "iq_cfg.svh"

module inst_queue (
	input  logic              clk,
	input  logic              rst,
	input  logic              flush,
	input  logic              push,
	input  iq_pkg::iq_entry_t push_entry,
	input  logic              pop,
	output iq_pkg::iq_entry_t head,
	output logic              not_empty,
	output logic              full
);

	localparam int PTR_W = $clog2(`IQ_DEPTH);

	iq_pkg::iq_entry_t mem [`IQ_DEPTH];
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W:0]    count; // one extra bit to tell full from empty

	assign head      = mem[rd_ptr];
	assign not_empty = (count != '0) && !flush; // head is dead in a flush cycle
	assign full      = (count == (PTR_W+1)'(`IQ_DEPTH));

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // both or neither, no change
			endcase
		end
	end

	// payload only
	always_ff @(posedge clk) begin
		if (push && !flush)
			mem[wr_ptr] <= push_entry;
	end

	// fetch gates on full, dispatch gates on not_empty
	assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("push into a full queue");
	assert property (@(posedge clk) disable iff (rst) pop |-> not_empty)
		else $error("pop from an empty queue");

endmodule

/* hw/iq_cfg.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front end sizes; IQ_DEPTH, ROB_DEPTH and RS_DEPTH must be powers of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// data and address width
`define XLEN 32

`define IQ_DEPTH 16 // instruction queue entries
`define ROB_DEPTH 16 // only sets the tag width here
`define RS_DEPTH 8 // sets the rs index width

// prediction table index, taken from inst[11:0]
`define BHT_INDEX_BITS 12

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

/* hw/iq_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared front end types; tag and index widths follow the cfg depths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "iq_cfg.svh"

package iq_pkg;

	// coarse class, picks the routing at dispatch
	typedef enum logic [2:0] {
		class_alu       = 3'd0, // op and op-imm
		class_lui_auipc = 3'd1,
		class_branch    = 3'd2,
		class_jal       = 3'd3,
		class_jalr      = 3'd4,
		class_load      = 3'd5,
		class_store     = 3'd6,
		class_illegal   = 3'd7  // unknown opcode, goes to the rs
	} inst_class_e;

	// rob position of an in-flight instruction
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

	// reservation station slot
	typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;

	// one queue slot, decoded once at fetch
	typedef struct packed {
		logic [`XLEN-1:0] inst;
		logic [`XLEN-1:0] pc;
		inst_class_e      cls;
		logic [4:0]       rd; // zero for branch and store
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] target; // pc+imm, branches only
		logic             pred_taken;
		logic             needs_rs1; // for the operand stage downstream
		logic             needs_rs2;
	} iq_entry_t;

endpackage

/* hw/iq_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front end top; cache, memory, bht, rob, rs and slb live outside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "iq_cfg.svh"

module iq_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       flush,
	input  logic [`XLEN-1:0]           flush_pc,
	output logic [`XLEN-1:0]           icache_addr,
	input  logic                       icache_hit,
	input  logic [`XLEN-1:0]           icache_data,
	output logic                       icache_fill,
	output logic [`XLEN-1:0]           icache_fill_addr,
	output logic [`XLEN-1:0]           icache_fill_data,
	output logic                       mem_req,
	output logic [`XLEN-1:0]           mem_addr,
	input  logic                       mem_ok,
	input  logic [`XLEN-1:0]           mem_data,
	output logic [`BHT_INDEX_BITS-1:0] bht_index,
	input  logic                       bht_taken,
	input  logic                       rob_full,
	input  iq_pkg::rob_tag_t           rob_tail_tag,
	output logic                       rob_alloc,
	output logic [`XLEN-1:0]           rob_pc,
	output logic [`XLEN-1:0]           rob_inst,
	output iq_pkg::inst_class_e        rob_class,
	output logic [4:0]                 rob_dest,
	output logic [`XLEN-1:0]           rob_target,
	output logic                       rob_pred_taken,
	input  logic                       rs_free,
	input  iq_pkg::rs_idx_t            rs_free_idx,
	output logic                       rs_alloc,
	output iq_pkg::rs_idx_t            rs_idx,
	output logic [`XLEN-1:0]           rs_inst,
	output logic [`XLEN-1:0]           rs_pc,
	output logic [`XLEN-1:0]           rs_imm,
	output logic [`XLEN-1:0]           rs_target,
	output iq_pkg::rob_tag_t           rs_tag,
	input  logic                       slb_full,
	output logic                       slb_alloc,
	output logic [`XLEN-1:0]           slb_inst,
	output logic [`XLEN-1:0]           slb_pc,
	output logic [`XLEN-1:0]           slb_imm,
	output iq_pkg::rob_tag_t           slb_tag,
	output logic                       rename_we,
	output logic [4:0]                 rename_rd,
	output iq_pkg::rob_tag_t           rename_tag
);

	logic              push;
	iq_pkg::iq_entry_t push_entry;
	logic              iq_full;
	logic              pop;
	iq_pkg::iq_entry_t head;
	logic              not_empty;

	fetch_unit i_fetch_unit (
		.clk, .rst, .flush, .flush_pc,
		.icache_addr, .icache_hit, .icache_data,
		.icache_fill, .icache_fill_addr, .icache_fill_data,
		.mem_req, .mem_addr, .mem_ok, .mem_data,
		.bht_index, .bht_taken,
		.iq_full, .push, .push_entry
	);

	inst_queue i_inst_queue (
		.clk, .rst, .flush,
		.push, .push_entry,
		.pop, .head, .not_empty,
		.full (iq_full)
	);

	dispatch_unit i_dispatch_unit (
		.head, .not_empty, .pop,
		.rob_full, .rob_tail_tag, .rob_alloc, .rob_pc, .rob_inst, .rob_class,
		.rob_dest, .rob_target, .rob_pred_taken,
		.rs_free, .rs_free_idx, .rs_alloc, .rs_idx, .rs_inst, .rs_pc, .rs_imm,
		.rs_target, .rs_tag,
		.slb_full, .slb_alloc, .slb_inst, .slb_pc, .slb_imm, .slb_tag,
		.rename_we, .rename_rd, .rename_tag
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_iq -f src.f -o sim_tb_iq

out="$(./obj_dir/sim_tb_iq)"
echo "$out"

if grep -qx "=== PASS ===" <<< "$out"; then
	exit 0
else
	exit 1
fi

/* src.f */
+incdir+hw
hw/iq_pkg.sv
hw/inst_decode.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/dispatch_unit.sv
hw/iq_top.sv
dv/tb_iq.sv
